//--- design/cp0IntSource.sv
// Interrupt sources for CP0
`timescale 1ns/1ps
`default_nettype none

module cp0IntSource (
    input  logic           clk,
    input  logic           rst,
    input  excPkg::hwInt_t hwInt,
    input  excPkg::word_t  count,
    input  excPkg::word_t  compare,
    input  logic           compareWr,
    output excPkg::hwInt_t hwPending,
    output logic           timerIrq
);
    import excPkg::*;

    hwInt_t hwMeta;     // first stage, may be metastable
    hwInt_t hwSync;

    always_ff @(posedge clk) begin
        if (rst) begin
            hwMeta <= '0;
            hwSync <= '0;
        end else begin
            hwMeta <= hwInt;
            hwSync <= hwMeta;
        end
    end

    assign hwPending = hwSync;

    // sticky until software rewrites Compare
    always_ff @(posedge clk) begin
        if (rst) begin
            timerIrq <= 1'b0;
        end else if (compareWr) begin
            timerIrq <= 1'b0;
        end else if (count == compare) begin
            timerIrq <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/cp0Regs.sv
// CP0 register file
`timescale 1ns/1ps
`default_nettype none
`include "excConsts.svh"

module cp0Regs (
    input  logic             clk,
    input  logic             rst,
    cp0StatusIf.regs         cpu,
    input  excPkg::hwInt_t   hwPending,
    input  logic             timerIrq,
    input  logic             wrEn,
    input  excPkg::cp0Addr_t wrAddr,
    input  excPkg::word_t    wrData,
    input  excPkg::cp0Addr_t rdAddr,
    output excPkg::word_t    rdData,
    output excPkg::word_t    count,
    output excPkg::word_t    compare,
    output logic             compareWr
);
    import excPkg::*;

    logic     statusBev;
    intMask_t statusIm;
    logic     statusExl;
    logic     statusIe;
    logic [1:0] causeIpSw;   // software interrupt bits
    excCode_t causeCode;
    word_t    epc;
    word_t    badVAddr;
    word_t    ebase;
    hwInt_t   causeIpHw;
    logic [3:0] countDiv;
    logic     countTick;
    word_t    statusWord;
    word_t    causeWord;

    function automatic logic mtc0(input cp0Addr_t num);
        return wrEn && (wrAddr == num);
    endfunction

    assign compareWr = mtc0(`CP0_COMPARE);
    assign causeIpHw = hwPending | {timerIrq, 5'b0};   // timer shares IP7

    assign countTick = (countDiv == `CP0_COUNT_PRESCALE - 4'd1);

    always_ff @(posedge clk) begin
        if (rst || countTick) begin
            countDiv <= '0;
        end else begin
            countDiv <= countDiv + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            compare <= 32'hffffffff;
        end else begin
            if (mtc0(`CP0_COUNT)) begin
                count <= wrData;
            end else if (countTick) begin
                count <= count + 32'd1;
            end
            if (compareWr) begin
                compare <= wrData;
            end
        end
    end

    // commit is applied last so it overrides an MTC0 in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            statusBev <= 1'b1;
            statusIm  <= '0;
            statusExl <= 1'b0;
            statusIe  <= 1'b0;
            causeIpSw <= '0;
            causeCode <= INT;
            epc       <= '0;
            ebase     <= `EBASE_RESET;
        end else begin
            if (mtc0(`CP0_STATUS)) begin
                statusBev <= wrData[22];
                statusIm  <= wrData[15:8];
                statusExl <= wrData[1];
                statusIe  <= wrData[0];
            end
            if (mtc0(`CP0_CAUSE)) begin
                causeIpSw <= wrData[9:8];
            end
            if (mtc0(`CP0_EPC)) begin
                epc <= wrData;
            end
            if (mtc0(`CP0_EBASE)) begin
                ebase[29:12] <= wrData[29:12];   // exception base only
            end
            if (cpu.commitExc) begin
                statusExl <= 1'b1;
                causeCode <= cpu.commitCode;
                epc       <= cpu.commitPc;
            end else if (cpu.commitEret) begin
                statusExl <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu.commitExc && cpu.badAddrValid) begin
            badVAddr <= cpu.commitBadAddr;
        end
    end

    assign statusWord = {9'b0, statusBev, 6'b0, statusIm, 6'b0, statusExl, statusIe};
    assign causeWord  = {1'b0, timerIrq, 14'b0, causeIpHw, causeIpSw, 1'b0, causeCode, 2'b0};

    always_comb begin
        case (rdAddr)
            `CP0_BADVADDR: rdData = badVAddr;
            `CP0_COUNT:    rdData = count;
            `CP0_COMPARE:  rdData = compare;
            `CP0_STATUS:   rdData = statusWord;
            `CP0_CAUSE:    rdData = causeWord;
            `CP0_EPC:      rdData = epc;
            `CP0_EBASE:    rdData = ebase;
            default:       rdData = '0;
        endcase
    end

    assign cpu.statusBev = statusBev;
    assign cpu.statusIm  = statusIm;
    assign cpu.statusExl = statusExl;
    assign cpu.statusIe  = statusIe;
    assign cpu.causeIp   = {causeIpHw, causeIpSw};
    assign cpu.ebase     = ebase;
    assign cpu.epc       = epc;

endmodule

`default_nettype wire

//--- design/cp0StatusIf.sv
// CP0 view and commit bus
`timescale 1ns/1ps
`default_nettype none

interface cp0StatusIf;
    import excPkg::*;

    logic     statusBev;
    intMask_t statusIm;
    logic     statusExl;
    logic     statusIe;
    intMask_t causeIp;       // IP7..0, hw and sw together
    word_t    ebase;
    word_t    epc;

    logic     commitExc;     // exception taken this cycle
    excCode_t commitCode;
    word_t    commitPc;
    word_t    commitBadAddr;
    logic     badAddrValid;
    logic     commitEret;

    modport regs (
        output statusBev, statusIm, statusExl, statusIe, causeIp, ebase, epc,
        input  commitExc, commitCode, commitPc, commitBadAddr, badAddrValid, commitEret
    );

    modport resolver (
        input  statusBev, statusIm, statusExl, statusIe, causeIp, ebase, epc,
        output commitExc, commitCode, commitPc, commitBadAddr, badAddrValid, commitEret
    );

endinterface

`default_nettype wire

//--- design/excConsts.svh
// Exception block constants
`ifndef EXC_CONSTS_SVH
`define EXC_CONSTS_SVH

// entry vectors
`define EXC_BOOT_BASE      32'hbfc00200
`define EXC_VEC_OFFSET     32'h00000180
`define EBASE_RESET        32'h80000000

// CP0 register numbers, select 0 only
`define CP0_BADVADDR       5'd8
`define CP0_COUNT          5'd9
`define CP0_COMPARE        5'd11
`define CP0_STATUS         5'd12
`define CP0_CAUSE          5'd13
`define CP0_EPC            5'd14
`define CP0_EBASE          5'd15

// cycles per Count increment
`define CP0_COUNT_PRESCALE 4'd2

`endif

//--- design/excPkg.sv
// Exception block types
`default_nettype none

package excPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  cp0Addr_t;
    typedef logic [7:0]  intMask_t;
    typedef logic [5:0]  hwInt_t;

    // pending causes gathered by IF/ID/EXE/MEM
    typedef struct packed {
        logic refetch;
        logic reservedInstr;
        logic copUnusable;
        logic syscall;
        logic brk;
        logic eret;
        logic trap;
        logic overflow;
        logic adelData;
        logic adesData;
    } excFlags_t;

    typedef struct packed {
        logic regWr;
        logic hiWr;
        logic loWr;
    } regsWr_t;

    typedef enum logic [3:0] {
        EXC_NONE,
        EXC_INT,
        EXC_REFETCH,
        EXC_ADEL_IF,
        EXC_CPU,
        EXC_RI,
        EXC_SYS,
        EXC_BP,
        EXC_ERET,
        EXC_TR,
        EXC_OV,
        EXC_ADES,
        EXC_ADEL
    } excKind_t;

    // Cause.ExcCode encodings
    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        CPU  = 5'd11,
        OV   = 5'd12,
        TR   = 5'd13
    } excCode_t;

    typedef enum logic [1:0] {
        ENTRY_NONE,
        ENTRY_EXC,
        ENTRY_ERET,
        ENTRY_REFETCH
    } entrySel_t;

endpackage

`default_nettype wire

//--- design/excResolver.sv
// MEM stage exception resolver
`timescale 1ns/1ps
`default_nettype none
`include "excConsts.svh"

module excResolver (
    cp0StatusIf.resolver        cpu,
    input  logic                memValid,
    input  excPkg::word_t       memPc,
    input  excPkg::word_t       memAddr,
    input  excPkg::excFlags_t   memFlags,
    input  excPkg::regsWr_t     memRegsWr,
    output excPkg::excKind_t    excKind,
    output logic                flush,
    output excPkg::regsWr_t     regsWrFinal,
    output logic                redirectValid,
    output excPkg::word_t       redirectPc
);
    import excPkg::*;

    logic      intReq;
    logic      adelIf;
    entrySel_t entrySel;
    word_t     vecBase;
    word_t     excVector;

    // interrupts only when not already in an exception handler
    assign intReq = ((cpu.causeIp & cpu.statusIm) != 8'b0) && !cpu.statusExl && cpu.statusIe;
    assign adelIf = (memPc[1:0] != 2'b00);

    always_comb begin
        if (!memValid)                   excKind = EXC_NONE;
        else if (intReq)                 excKind = EXC_INT;
        else if (memFlags.refetch)       excKind = EXC_REFETCH;
        else if (adelIf)                 excKind = EXC_ADEL_IF;
        else if (memFlags.copUnusable)   excKind = EXC_CPU;
        else if (memFlags.reservedInstr) excKind = EXC_RI;
        else if (memFlags.syscall)       excKind = EXC_SYS;
        else if (memFlags.brk)           excKind = EXC_BP;
        else if (memFlags.eret)          excKind = EXC_ERET;
        else if (memFlags.trap)          excKind = EXC_TR;
        else if (memFlags.overflow)      excKind = EXC_OV;
        else if (memFlags.adesData)      excKind = EXC_ADES;
        else if (memFlags.adelData)      excKind = EXC_ADEL;
        else                             excKind = EXC_NONE;
    end

    always_comb begin
        case (excKind)
            EXC_NONE, EXC_REFETCH: begin
                flush       = 1'b0;
                regsWrFinal = memRegsWr;
            end
            default: begin
                flush       = 1'b1;
                regsWrFinal = '0;   // faulting instr must not retire
            end
        endcase
    end

    always_comb begin
        case (excKind)
            EXC_NONE:    entrySel = ENTRY_NONE;
            EXC_REFETCH: entrySel = ENTRY_REFETCH;
            EXC_ERET:    entrySel = ENTRY_ERET;
            default:     entrySel = ENTRY_EXC;
        endcase
    end

    assign vecBase   = cpu.statusBev ? `EXC_BOOT_BASE : cpu.ebase;
    assign excVector = vecBase + `EXC_VEC_OFFSET;   // no TLB refill, offset fixed

    always_comb begin
        case (entrySel)
            ENTRY_EXC:     redirectPc = excVector;
            ENTRY_ERET:    redirectPc = cpu.epc;
            ENTRY_REFETCH: redirectPc = memPc;
            default:       redirectPc = '0;
        endcase
    end

    assign redirectValid = (entrySel != ENTRY_NONE);

    always_comb begin
        case (excKind)
            EXC_ADEL_IF: cpu.commitCode = ADEL;
            EXC_CPU:     cpu.commitCode = CPU;
            EXC_RI:      cpu.commitCode = RI;
            EXC_SYS:     cpu.commitCode = SYS;
            EXC_BP:      cpu.commitCode = BP;
            EXC_TR:      cpu.commitCode = TR;
            EXC_OV:      cpu.commitCode = OV;
            EXC_ADES:    cpu.commitCode = ADES;
            EXC_ADEL:    cpu.commitCode = ADEL;
            default:     cpu.commitCode = INT;
        endcase
    end

    assign cpu.commitExc     = (entrySel == ENTRY_EXC);
    assign cpu.commitEret    = (entrySel == ENTRY_ERET);
    assign cpu.commitPc      = memPc;
    assign cpu.commitBadAddr = (excKind == EXC_ADEL_IF) ? memPc : memAddr;
    assign cpu.badAddrValid  = (excKind == EXC_ADEL_IF) || (excKind == EXC_ADES)
                               || (excKind == EXC_ADEL);

endmodule

`default_nettype wire

//--- design/excTop.sv
// Precise exception block top
`timescale 1ns/1ps
`default_nettype none

module excTop (
    input  logic               clk,
    input  logic               rst,
    input  excPkg::hwInt_t     hwInt,
    input  logic               memValid,
    input  excPkg::word_t      memPc,
    input  excPkg::word_t      memAddr,
    input  excPkg::excFlags_t  memFlags,
    input  excPkg::regsWr_t    memRegsWr,
    input  logic               cp0WrEn,
    input  excPkg::cp0Addr_t   cp0WrAddr,
    input  excPkg::word_t      cp0WrData,
    input  excPkg::cp0Addr_t   cp0RdAddr,
    output excPkg::word_t      cp0RdData,
    output excPkg::excKind_t   excKind,
    output logic               flush,
    output excPkg::regsWr_t    regsWrFinal,
    output logic               redirectValid,
    output excPkg::word_t      redirectPc
);
    import excPkg::*;

    hwInt_t hwPending;
    logic   timerIrq;
    word_t  count;
    word_t  compare;
    logic   compareWr;

    cp0StatusIf cp0Bus ();

    excResolver i_excResolver (
        .cpu           (cp0Bus.resolver),
        .memValid      (memValid),
        .memPc         (memPc),
        .memAddr       (memAddr),
        .memFlags      (memFlags),
        .memRegsWr     (memRegsWr),
        .excKind       (excKind),
        .flush         (flush),
        .regsWrFinal   (regsWrFinal),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    cp0Regs i_cp0Regs (
        .clk       (clk),
        .rst       (rst),
        .cpu       (cp0Bus.regs),
        .hwPending (hwPending),
        .timerIrq  (timerIrq),
        .wrEn      (cp0WrEn),
        .wrAddr    (cp0WrAddr),
        .wrData    (cp0WrData),
        .rdAddr    (cp0RdAddr),
        .rdData    (cp0RdData),
        .count     (count),
        .compare   (compare),
        .compareWr (compareWr)
    );

    cp0IntSource i_cp0IntSource (
        .clk       (clk),
        .rst       (rst),
        .hwInt     (hwInt),
        .count     (count),
        .compare   (compare),
        .compareWr (compareWr),
        .hwPending (hwPending),
        .timerIrq  (timerIrq)
    );

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/excPkg.sv
design/cp0StatusIf.sv
design/cp0IntSource.sv
design/cp0Regs.sv
design/excResolver.sv
design/excTop.sv
verif/excTb.sv

//--- run.sh
#!/bin/sh
# build and run the exception block testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module excTb -o excSim; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/excSim; then
    echo "simulation failed"
    exit 1
fi

exit 0

//--- verif/excTb.sv
// Exception block testbench
`timescale 1ns/1ps
`default_nettype none
`include "excConsts.svh"

module excTb;
    import excPkg::*;

    logic      clk;
    logic      rst;
    hwInt_t    hwInt;
    logic      memValid;
    word_t     memPc;
    word_t     memAddr;
    excFlags_t memFlags;
    regsWr_t   memRegsWr;
    logic      cp0WrEn;
    cp0Addr_t  cp0WrAddr;
    word_t     cp0WrData;
    cp0Addr_t  cp0RdAddr;
    word_t     cp0RdData;
    excKind_t  excKind;
    logic      flush;
    regsWr_t   regsWrFinal;
    logic      redirectValid;
    word_t     redirectPc;

    word_t     lfsrState;
    hwInt_t    hwLines;     // level held on hwInt by every driven cycle
    excKind_t  curKind;

    // reference model of the CP0 state
    logic      mBev;
    intMask_t  mIm;
    logic      mExl;
    logic      mIe;
    logic [1:0] mIpSw;
    excCode_t  mCode;
    word_t     mEpc;
    word_t     mEbase;
    word_t     mBad;
    logic      mBadValid;
    word_t     mCount;
    word_t     mCompare;
    logic      mTimer;
    logic      mPhase;      // Count advances when set
    hwInt_t    mMeta;
    hwInt_t    mSync;

    excTop i_excTop (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t lfsrNext(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t takeBits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    task automatic checkKind(input string name, input excKind_t got, input excKind_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic checkRegsWr(input string name, input regsWr_t got, input regsWr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic hwInt_t modelHwIp();
        return mSync | {mTimer, 5'b00000};   // timer on IP7
    endfunction

    // priority INT, REFETCH, ADEL_IF, CPU, RI, SYS, BP, ERET, TR, OV, ADES, ADEL
    function automatic excKind_t refKind(input logic v, input excFlags_t f, input word_t pc,
                                         input intMask_t ip);
        if (!v) return EXC_NONE;
        if (((ip & mIm) != 8'h00) && !mExl && mIe) return EXC_INT;
        if (f.refetch) return EXC_REFETCH;
        if (pc[1:0] != 2'b00) return EXC_ADEL_IF;
        if (f.copUnusable) return EXC_CPU;
        if (f.reservedInstr) return EXC_RI;
        if (f.syscall) return EXC_SYS;
        if (f.brk) return EXC_BP;
        if (f.eret) return EXC_ERET;
        if (f.trap) return EXC_TR;
        if (f.overflow) return EXC_OV;
        if (f.adesData) return EXC_ADES;
        if (f.adelData) return EXC_ADEL;
        return EXC_NONE;
    endfunction

    function automatic excCode_t refCode(input excKind_t kind);
        case (kind)
            EXC_ADEL_IF, EXC_ADEL: return ADEL;
            EXC_ADES: return ADES;
            EXC_CPU:  return CPU;
            EXC_RI:   return RI;
            EXC_SYS:  return SYS;
            EXC_BP:   return BP;
            EXC_TR:   return TR;
            EXC_OV:   return OV;
            default:  return INT;
        endcase
    endfunction

    function automatic word_t refRedirect(input excKind_t kind, input word_t pc);
        case (kind)
            EXC_REFETCH: return pc;
            EXC_ERET:    return mEpc;
            default:     return (mBev ? `EXC_BOOT_BASE : mEbase) + `EXC_VEC_OFFSET;
        endcase
    endfunction

    function automatic word_t refRead(input cp0Addr_t addr);
        case (addr)
            `CP0_BADVADDR: return mBad;
            `CP0_COUNT:    return mCount;
            `CP0_COMPARE:  return mCompare;
            `CP0_STATUS:   return {9'b0, mBev, 6'b0, mIm, 6'b0, mExl, mIe};
            `CP0_CAUSE:    return {1'b0, mTimer, 14'b0, modelHwIp(), mIpSw, 1'b0, mCode, 2'b0};
            `CP0_EPC:      return mEpc;
            `CP0_EBASE:    return mEbase;
            default:       return '0;
        endcase
    endfunction

    function automatic logic writesTo(input cp0Addr_t a);
        return cp0WrEn && (cp0WrAddr == a);
    endfunction

    task automatic resetModel();
        mBev      = 1'b1;
        mIm       = '0;
        mExl      = 1'b0;
        mIe       = 1'b0;
        mIpSw     = '0;
        mCode     = INT;
        mEpc      = '0;
        mEbase    = `EBASE_RESET;
        mBad      = '0;
        mBadValid = 1'b0;
        mCount    = '0;
        mCompare  = 32'hffff_ffff;
        mTimer    = 1'b0;
        mPhase    = 1'b0;
        mMeta     = '0;
        mSync     = '0;
    endtask

    task automatic checkOutputs();
        logic flushing;
        curKind  = refKind(memValid, memFlags, memPc, {modelHwIp(), mIpSw});
        flushing = (curKind != EXC_NONE) && (curKind != EXC_REFETCH);
        checkKind("excKind", excKind, curKind);
        checkFlag("flush", flush, flushing);
        checkRegsWr("regsWrFinal", regsWrFinal, flushing ? regsWr_t'(3'b000) : memRegsWr);
        checkFlag("redirectValid", redirectValid, curKind != EXC_NONE);
        if (curKind != EXC_NONE) begin
            checkWord("redirectPc", redirectPc, refRedirect(curKind, memPc));
        end
        if ((cp0RdAddr != `CP0_BADVADDR) || mBadValid) begin
            checkWord("cp0RdData", cp0RdData, refRead(cp0RdAddr));
        end
    endtask

    // state after the coming rising edge
    task automatic updateModel();
        logic tick;
        tick = mPhase;
        if (writesTo(`CP0_COMPARE)) begin
            mTimer = 1'b0;
        end else if (mCount == mCompare) begin
            mTimer = 1'b1;
        end
        mPhase = ~mPhase;
        if (writesTo(`CP0_COUNT)) begin
            mCount = cp0WrData;
        end else if (tick) begin
            mCount = mCount + 32'd1;
        end
        if (writesTo(`CP0_COMPARE)) begin
            mCompare = cp0WrData;
        end
        mSync = mMeta;
        mMeta = hwInt;
        if (writesTo(`CP0_STATUS)) begin
            mBev = cp0WrData[22];
            mIm  = cp0WrData[15:8];
            mExl = cp0WrData[1];
            mIe  = cp0WrData[0];
        end
        if (writesTo(`CP0_CAUSE)) begin
            mIpSw = cp0WrData[9:8];
        end
        if (writesTo(`CP0_EPC)) begin
            mEpc = cp0WrData;
        end
        if (writesTo(`CP0_EBASE)) begin
            mEbase[29:12] = cp0WrData[29:12];
        end
        if (curKind == EXC_ERET) begin
            mExl = 1'b0;
        end else if (curKind != EXC_NONE && curKind != EXC_REFETCH) begin
            mExl  = 1'b1;
            mCode = refCode(curKind);
            mEpc  = memPc;
            if (curKind == EXC_ADEL_IF) begin
                mBad      = memPc;
                mBadValid = 1'b1;
            end else if (curKind == EXC_ADES || curKind == EXC_ADEL) begin
                mBad      = memAddr;
                mBadValid = 1'b1;
            end
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rst !== 1'b0) begin
                resetModel();
            end else begin
                checkOutputs();
                updateModel();
            end
        end
    end

    task automatic driveCycle(input logic v, input word_t pc, input word_t addr,
                              input excFlags_t fl, input regsWr_t rw, input logic we,
                              input cp0Addr_t wa, input word_t wd, input cp0Addr_t ra);
        @(posedge clk);
        memValid  <= v;
        memPc     <= pc;
        memAddr   <= addr;
        memFlags  <= fl;
        memRegsWr <= rw;
        cp0WrEn   <= we;
        cp0WrAddr <= wa;
        cp0WrData <= wd;
        cp0RdAddr <= ra;
        hwInt     <= hwLines;
        @(negedge clk);     // outputs settled
    endtask

    task automatic issueInstr(input word_t pc, input word_t addr, input excFlags_t fl,
                              input regsWr_t rw);
        driveCycle(1'b1, pc, addr, fl, rw, 1'b0, '0, '0, '0);
    endtask

    task automatic writeCp0(input cp0Addr_t a, input word_t d);
        driveCycle(1'b0, '0, '0, '0, '0, 1'b1, a, d, '0);
    endtask

    task automatic readCp0(input cp0Addr_t a, output word_t d);
        driveCycle(1'b0, '0, '0, '0, '0, 1'b0, '0, '0, a);
        d = cp0RdData;
    endtask

    task automatic expectCp0(input string name, input cp0Addr_t a, input word_t mask,
                             input word_t exp);
        word_t v;
        readCp0(a, v);
        checkWord(name, v & mask, exp);
    endtask

    task automatic returnFromExc(input word_t epcExp);
        excFlags_t fl;
        fl      = '0;
        fl.eret = 1'b1;
        issueInstr(32'h8000_0180, '0, fl, 3'b001);
        checkKind("excKind", excKind, EXC_ERET);
        checkWord("redirectPc", redirectPc, epcExp);
        expectCp0("Status.EXL", `CP0_STATUS, 32'h2, 32'h0);
    endtask

    task automatic waitCauseBit(input int bitIdx, input int limit);
        word_t cause;
        int    waited;
        waited = 0;
        readCp0(`CP0_CAUSE, cause);
        while (!cause[bitIdx]) begin
            waited++;
            if (waited > limit) begin
                $display("Timeout waiting for Cause bit %0d to rise", bitIdx);
                $display("Verification failed");
                $fatal(1);
            end else begin
                readCp0(`CP0_CAUSE, cause);
            end
        end
    endtask

    task automatic randomCycle();
        word_t      pc;
        logic       we;
        logic [2:0] sel;
        cp0Addr_t   wa;
        excFlags_t  fl;
        regsWr_t    rw;
        pc = takeBits(32) & 32'hffff_fffc;
        if (takeBits(3) == 32'd0) begin
            pc[1:0] = 2'(takeBits(2)) | 2'b01;     // misaligned fetch
        end
        we  = (takeBits(3) == 32'd0);
        sel = 3'(takeBits(3));
        case (sel)
            3'd0:    wa = `CP0_CAUSE;
            3'd1:    wa = `CP0_EBASE;
            3'd2:    wa = `CP0_EPC;
            3'd3:    wa = `CP0_COMPARE;
            3'd4:    wa = `CP0_COUNT;
            default: wa = `CP0_STATUS;
        endcase
        fl = 10'(takeBits(10) & takeBits(10) & takeBits(10));   // sparse flags
        rw = 3'(takeBits(3));
        driveCycle(takeBits(2) != 32'd0, pc, takeBits(32), fl, rw, we, wa, takeBits(32),
                   5'(takeBits(5)));
    endtask

    initial begin
        word_t     cnt;
        word_t     ebaseVal;
        excFlags_t fl;
        lfsrState = 32'h498d_417d;
        hwLines   = '0;
        rst       = 1'b1;
        hwInt     = '0;
        memValid  = 1'b0;
        memPc     = '0;
        memAddr   = '0;
        memFlags  = '0;
        memRegsWr = '0;
        cp0WrEn   = 1'b0;
        cp0WrAddr = '0;
        cp0WrData = '0;
        cp0RdAddr = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // vector from EBase with BEV clear
        ebaseVal = takeBits(32);
        writeCp0(`CP0_EBASE, ebaseVal);
        writeCp0(`CP0_STATUS, 32'h0);
        fl         = '0;
        fl.syscall = 1'b1;
        issueInstr(32'h0040_0100, '0, fl, 3'b101);
        checkKind("excKind", excKind, EXC_SYS);
        checkWord("redirectPc", redirectPc,
                  {2'b10, ebaseVal[29:12], 12'h000} + `EXC_VEC_OFFSET);
        expectCp0("EPC", `CP0_EPC, 32'hffff_ffff, 32'h0040_0100);
        expectCp0("Cause.ExcCode", `CP0_CAUSE, 32'h7c, {25'b0, SYS, 2'b0});
        expectCp0("Status.EXL", `CP0_STATUS, 32'h2, 32'h2);
        returnFromExc(32'h0040_0100);

        // boot vector
        writeCp0(`CP0_STATUS, 32'h0040_0000);
        fl     = '0;
        fl.brk = 1'b1;
        issueInstr(32'h0040_0200, '0, fl, 3'b111);
        checkKind("excKind", excKind, EXC_BP);
        checkWord("redirectPc", redirectPc, `EXC_BOOT_BASE + `EXC_VEC_OFFSET);
        checkRegsWr("regsWrFinal", regsWrFinal, 3'b000);
        returnFromExc(32'h0040_0200);

        // address errors load BadVAddr
        fl = '0;
        issueInstr(32'h0040_0302, '0, fl, 3'b001);
        checkKind("excKind", excKind, EXC_ADEL_IF);
        expectCp0("BadVAddr", `CP0_BADVADDR, 32'hffff_ffff, 32'h0040_0302);
        expectCp0("Cause.ExcCode", `CP0_CAUSE, 32'h7c, {25'b0, ADEL, 2'b0});
        returnFromExc(32'h0040_0302);
        fl.adesData = 1'b1;
        issueInstr(32'h0040_0304, 32'h1000_0003, fl, 3'b000);
        checkKind("excKind", excKind, EXC_ADES);
        expectCp0("BadVAddr", `CP0_BADVADDR, 32'hffff_ffff, 32'h1000_0003);
        expectCp0("Cause.ExcCode", `CP0_CAUSE, 32'h7c, {25'b0, ADES, 2'b0});
        returnFromExc(32'h0040_0304);

        // refetch keeps write-back and skips the flush
        fl         = '0;
        fl.refetch = 1'b1;
        issueInstr(32'h0040_0400, '0, fl, 3'b111);
        checkKind("excKind", excKind, EXC_REFETCH);
        checkFlag("flush", flush, 1'b0);
        checkRegsWr("regsWrFinal", regsWrFinal, 3'b111);
        checkWord("redirectPc", redirectPc, 32'h0040_0400);

        // software interrupt then masked by EXL
        writeCp0(`CP0_STATUS, 32'h0000_0101);
        writeCp0(`CP0_CAUSE, 32'h0000_0100);
        fl = '0;
        issueInstr(32'h0040_0500, '0, fl, 3'b001);
        checkKind("excKind", excKind, EXC_INT);
        issueInstr(32'h0040_0504, '0, fl, 3'b001);
        checkKind("excKind", excKind, EXC_NONE);
        writeCp0(`CP0_CAUSE, 32'h0);
        writeCp0(`CP0_STATUS, 32'h0);

        // hardware line 0 lands on IP2
        writeCp0(`CP0_STATUS, 32'h0000_0401);
        hwLines = 6'b000001;
        waitCauseBit(10, 10);
        issueInstr(32'h0040_0600, '0, fl, 3'b001);
        checkKind("excKind", excKind, EXC_INT);
        hwLines = '0;
        writeCp0(`CP0_STATUS, 32'h0);

        // timer raises IP7 until Compare is rewritten
        readCp0(`CP0_COUNT, cnt);
        writeCp0(`CP0_COMPARE, cnt + 32'd6);
        waitCauseBit(15, 40);
        writeCp0(`CP0_COMPARE, 32'hffff_ffff);
        expectCp0("Cause.IP7", `CP0_CAUSE, 32'h0000_8000, 32'h0);

        for (int n = 0; n < 1500; n++) begin
            randomCycle();
        end
        @(posedge clk);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
